//--- nes_bus_pkg.sv
/*
 * Shared types and constants for the console CPU bus core.
 * Imported by the divider, DMA, controller port and bus mux blocks,
 * and by the top level that joins them.
 */

package nes_bus_pkg;

	typedef logic [15:0] addr_t;	// CPU side address
	typedef logic [7:0]  data_t;	// One bus byte

	// Master clock dividers
	localparam logic [3:0] CPU_DIV        = 4'd12;	// Master clocks per CPU cycle
	localparam logic [2:0] PPU_DIV        = 3'd4;	// Master clocks per PPU tick
	localparam logic [2:0] PAL_LONG_CYCLE = 3'd5;	// Last CPU cycle of the group gets one extra tick

	// Memory map
	localparam addr_t OAM_DATA_ADDR = 16'h2004;	// Sprite DMA write target
	localparam addr_t PPU_BASE      = 16'h2000;
	localparam addr_t PPU_END       = 16'h3FFF;	// Registers mirrored across the window

	// APU block is 4000 to 401F, match on the upper eleven bits
	localparam logic [10:0] APU_PAGE = 11'b0100_0000_000;

	localparam logic [4:0] REG_SPRITE_DMA = 5'h14;	// 4014
	localparam logic [4:0] REG_JOY1       = 5'h16;	// 4016, also the strobe register
	localparam logic [4:0] REG_JOY2       = 5'h17;	// 4017

	// Bit 0 set selects PAL clocking
	typedef enum logic [1:0] {
		NTSC  = 2'd0,
		PAL   = 2'd1,
		DENDY = 2'd2
	} sys_type_e;

	// Bit 0 pauses the CPU, bit 1 owns the bus
	typedef enum logic [1:0] {
		SPR_IDLE  = 2'b00,
		SPR_ALIGN = 2'b01,	// Halt or alignment cycle
		SPR_COPY  = 2'b11	// Get reads the page, put writes OAM
	} spr_state_e;

	typedef enum logic {
		DMC_IDLE  = 1'b0,
		DMC_FETCH = 1'b1	// Borrowed get cycle
	} dmc_state_e;

endpackage

//--- clock_divider.sv
/*
 * Master clock divider. Produces the one clock wide CPU, PPU and cart
 * enables, the get/put phase and the PPU register access slots.
 * PAL stretches every fifth CPU cycle by one PPU tick.
 */

`timescale 1ns/1ps

module clock_divider (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_bus_pkg::sys_type_e sys_type,
	output logic                   cpu_ce,
	output logic                   ppu_ce,
	output logic                   put_ce,
	output logic                   get_ce,
	output logic                   cart_ce,
	output logic                   put_cycle,
	output logic                   ppu_read_slot,
	output logic                   ppu_write_slot
);
	import nes_bus_pkg::*;

	logic [3:0] div_cpu;	// Runs 1 to CPU_DIV
	logic [2:0] div_ppu;	// Runs 1 to PPU_DIV
	logic [1:0] ppu_tick;	// PPU tick index inside the current CPU cycle
	logic [2:0] pal_count;	// Position in the PAL five cycle group
	sys_type_e  last_sys_type;
	logic       pal;
	logic       long_cycle;
	logic       stretch;

	assign pal = sys_type[0];

	// Fifth cycle of a PAL group is the long one
	assign long_cycle = pal && (pal_count == PAL_LONG_CYCLE - 3'd1);

	// Hold the CPU divider for the whole first PPU tick of the long cycle
	assign stretch = long_cycle && (ppu_tick == 2'd0);

	assign cpu_ce = (div_cpu == CPU_DIV);
	assign ppu_ce = (div_ppu == PPU_DIV);

	// Get/put split of the CPU enable
	assign put_ce = cpu_ce && put_cycle;
	assign get_ce = cpu_ce && !put_cycle;

	// Access slots move one tick later when the cycle is stretched
	assign ppu_write_slot = (ppu_tick == (long_cycle ? 2'd1 : 2'd0));
	assign ppu_read_slot  = (ppu_tick == (long_cycle ? 2'd2 : 2'd1));

	// Cart runs on the first PPU tick that sees CPU data
	assign cart_ce = ppu_ce && ppu_write_slot;

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cpu       <= 4'd1;
			div_ppu       <= 3'd1;
			ppu_tick      <= 2'd0;
			pal_count     <= 3'd0;
			put_cycle     <= 1'b1;	// First cycle after reset is a put
			last_sys_type <= sys_type;
		end else begin
			last_sys_type <= sys_type;

			if (last_sys_type != sys_type) begin
				// Realign everything on a system change
				div_cpu   <= 4'd1;
				div_ppu   <= 3'd1;
				ppu_tick  <= 2'd0;
				pal_count <= 3'd0;
			end else begin
				if (!stretch)
					div_cpu <= cpu_ce ? 4'd1 : div_cpu + 4'd1;

				div_ppu <= ppu_ce ? 3'd1 : div_ppu + 3'd1;

				// Restart tick count at each CPU cycle
				if (cpu_ce)
					ppu_tick <= 2'd0;
				else if (ppu_ce)
					ppu_tick <= ppu_tick + 2'd1;

				if (cpu_ce && pal)
					pal_count <= long_cycle ? 3'd0 : pal_count + 3'd1;
			end

			if (cpu_ce)
				put_cycle <= ~put_cycle;	// Phase flips every CPU cycle
		end
	end

endmodule

//--- dma_controller.sv
/*
 * Sprite and DMC DMA controller. Takes the bus from the CPU, reads on
 * get cycles and writes OAM on put cycles, and pauses the CPU meanwhile.
 * A DMC fetch steals one get cycle and the sprite copy resumes after it.
 */

`timescale 1ns/1ps

module dma_controller (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  logic               put_ce,
	input  logic               get_ce,
	input  logic               put_cycle,
	input  logic               sprite_trigger,
	input  logic               cpu_read,
	input  nes_bus_pkg::data_t cpu_wdata,
	input  nes_bus_pkg::data_t dma_rdata,
	input  logic               dmc_request,
	input  nes_bus_pkg::addr_t dmc_addr,
	output nes_bus_pkg::addr_t dma_addr,
	output logic               dma_active,
	output logic               dma_read,
	output nes_bus_pkg::data_t dma_wdata,
	output logic               dmc_ack,
	output logic               pause_cpu
);
	import nes_bus_pkg::*;

	spr_state_e spr_state;
	dmc_state_e dmc_state;
	logic       dmc_halt;	// Halt cycle seen, CPU now stopped on a read
	data_t      spr_page;	// Source page from the 4014 write
	logic [7:0] spr_index;
	data_t      spr_latch;	// Byte read on get, written on put
	logic       spr_copy;

	assign spr_copy = (spr_state == SPR_COPY);

	// DMC needs one halt cycle, then enters on a put so the fetch is a get
	always_ff @(posedge clk) begin
		if (reset) begin
			dmc_state <= DMC_IDLE;
			dmc_halt  <= 1'b0;
		end else if (cpu_ce) begin
			if (dmc_state == DMC_IDLE) begin
				if (dmc_halt && dmc_request && put_ce) begin
					dmc_state <= DMC_FETCH;
					dmc_halt  <= 1'b0;
				end else begin
					dmc_halt <= dmc_request && cpu_read;
				end
			end else if (get_ce) begin
				dmc_state <= DMC_IDLE;	// Single borrowed get cycle
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			spr_state <= SPR_IDLE;
		end else if (cpu_ce) begin
			case (spr_state)
				SPR_IDLE:
					if (sprite_trigger)
						spr_state <= SPR_ALIGN;
				SPR_ALIGN:
					// Leave on a put so the copy opens with a read
					if (cpu_read && put_ce)
						spr_state <= SPR_COPY;
				SPR_COPY:
					if (get_ce && dmc_state == DMC_FETCH)
						spr_state <= SPR_ALIGN;	// DMC took the read, realign
					else if (put_ce && spr_index == 8'hFF)
						spr_state <= SPR_IDLE;	// Last pair written
				default:
					spr_state <= SPR_IDLE;
			endcase
		end
	end

	// Source pointer and data latch
	always_ff @(posedge clk) begin
		if (cpu_ce) begin
			if (spr_state == SPR_IDLE && sprite_trigger) begin
				spr_page  <= cpu_wdata;
				spr_index <= 8'h00;
			end
			if (spr_copy && get_ce && dmc_state == DMC_IDLE)
				spr_latch <= dma_rdata;
			if (spr_copy && put_ce)
				spr_index <= spr_index + 8'd1;	// Advance only after the write
		end
	end

	assign dmc_ack    = (dmc_state == DMC_FETCH);	// Always a get cycle
	assign dma_active = dmc_ack || spr_copy;
	assign dma_read   = !put_cycle;
	assign dma_wdata  = spr_latch;
	assign pause_cpu  = (spr_state != SPR_IDLE) || dmc_request || dmc_ack;

	// DMC wins the bus, otherwise phase picks source or OAM port
	assign dma_addr = dmc_ack   ? dmc_addr :
	                  put_cycle ? OAM_DATA_ADDR : {spr_page, spr_index};

endmodule

//--- joypad_port.sv
/*
 * Controller port registers. Holds the strobe bits written to 4016 and
 * presents them at the next put cycle, pulses the port clocks on reads
 * and returns the selected port's data lines.
 */

`timescale 1ns/1ps

module joypad_port (
	input  logic               clk,
	input  logic               reset,
	input  logic               put_ce,
	input  logic               joy1_cs,
	input  logic               joy2_cs,
	input  logic               cpu_read,
	input  nes_bus_pkg::data_t cpu_wdata,
	input  logic [4:0]         joypad1_data,
	input  logic [4:0]         joypad2_data,
	output logic [2:0]         joypad_out,
	output logic [1:0]         joypad_clock,
	output logic [4:0]         joy_rdata
);

	logic [2:0] strobe_latch;	// Last value written to 4016
	logic       strobe_write;

	assign strobe_write = joy1_cs && !cpu_read;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe_latch <= 3'd0;
			joypad_out   <= 3'd0;
		end else begin
			if (strobe_write)
				strobe_latch <= cpu_wdata[2:0];
			// Output pins only change on put
			if (put_ce)
				joypad_out <= strobe_write ? cpu_wdata[2:0] : strobe_latch;
		end
	end

	// Clock line follows the read of each port
	assign joypad_clock = {joy2_cs && cpu_read, joy1_cs && cpu_read};

	assign joy_rdata = joy2_cs ? joypad2_data : joypad1_data;

endmodule

//--- cpu_bus_mux.sv
/*
 * CPU side bus selection. Chooses DMA or CPU as master, decodes the
 * PPU and APU windows, resolves read data by priority and keeps the
 * open bus value that unmapped reads return.
 */

`timescale 1ns/1ps

module cpu_bus_mux (
	input  logic               clk,
	input  logic               reset,
	input  logic               cpu_ce,
	input  nes_bus_pkg::addr_t cpu_addr,
	input  logic               cpu_rnw,
	input  nes_bus_pkg::data_t cpu_wdata,
	input  nes_bus_pkg::addr_t dma_addr,
	input  logic               dma_active,
	input  logic               dma_read,
	input  nes_bus_pkg::data_t dma_wdata,
	input  logic               ppu_read_slot,
	input  logic               ppu_write_slot,
	input  nes_bus_pkg::data_t ppu_rdata,
	input  logic               prg_allow,
	input  nes_bus_pkg::data_t prg_rdata,
	input  logic [4:0]         joy_rdata,
	output nes_bus_pkg::addr_t bus_addr,
	output logic               bus_read,
	output logic               bus_write,
	output nes_bus_pkg::data_t bus_dout,
	output logic               ppu_rd,
	output logic               ppu_wr,
	output logic               sprite_trigger,
	output logic               joy1_cs,
	output logic               joy2_cs,
	output nes_bus_pkg::data_t cpu_din,
	output nes_bus_pkg::data_t dma_rdata
);
	import nes_bus_pkg::*;

	logic  apu_cs;
	logic  ppu_cs;
	logic  joy_cs;
	data_t open_bus;	// Last value seen on the data bus
	data_t read_data;	// External sources without the controllers

	// Bus master
	assign bus_addr  = dma_active ? dma_addr : cpu_addr;
	assign bus_read  = dma_active ? dma_read : cpu_rnw;
	assign bus_write = dma_active ? !dma_read : !cpu_rnw;
	assign bus_dout  = dma_active ? dma_wdata : cpu_wdata;

	// Decode
	assign apu_cs  = (bus_addr[15:5] == APU_PAGE);
	assign ppu_cs  = (bus_addr >= PPU_BASE) && (bus_addr <= PPU_END);
	assign joy1_cs = apu_cs && (bus_addr[4:0] == REG_JOY1);
	assign joy2_cs = apu_cs && (bus_addr[4:0] == REG_JOY2);
	assign joy_cs  = joy1_cs || joy2_cs;

	assign sprite_trigger = apu_cs && (bus_addr[4:0] == REG_SPRITE_DMA) && bus_write;

	// PPU strobes land in their own tick of the CPU cycle
	assign ppu_rd = ppu_cs && bus_read && ppu_read_slot;
	assign ppu_wr = ppu_cs && bus_write && ppu_write_slot;

	assign read_data = ppu_cs    ? ppu_rdata :
	                   prg_allow ? prg_rdata : open_bus;

	// CPU read of a port, top three bits float from open bus
	assign cpu_din = (joy_cs && !dma_active) ? {open_bus[7:5], joy_rdata} : read_data;

	// DMA read of a port sees the live bus on the upper bits
	assign dma_rdata = (joy_cs && dma_active) ? {cpu_din[7:5], joy_rdata} : cpu_din;

	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= 8'h00;
		else if (!cpu_ce)
			open_bus <= bus_write ? bus_dout : dma_rdata;	// Frozen on the CPU edge
	end

endmodule

//--- nes_bus_top.sv
/*
 * Top level of the CPU bus core. Joins the clock divider, DMA
 * controller, controller port and bus mux. The external CPU must
 * hold its cycle while pause_cpu is high.
 */

`timescale 1ns/1ps

module nes_bus_top (
	input  logic                   clk,
	input  logic                   reset,
	input  nes_bus_pkg::sys_type_e sys_type,
	input  nes_bus_pkg::addr_t     cpu_addr,
	input  logic                   cpu_rnw,
	input  nes_bus_pkg::data_t     cpu_wdata,
	input  nes_bus_pkg::data_t     ppu_rdata,
	input  logic                   prg_allow,
	input  nes_bus_pkg::data_t     prg_rdata,
	input  logic                   dmc_request,
	input  nes_bus_pkg::addr_t     dmc_addr,
	input  logic [4:0]             joypad1_data,
	input  logic [4:0]             joypad2_data,
	output logic                   cpu_ce,
	output logic                   ppu_ce,
	output logic                   put_ce,
	output logic                   get_ce,
	output logic                   cart_ce,
	output nes_bus_pkg::addr_t     bus_addr,
	output logic                   bus_read,
	output logic                   bus_write,
	output nes_bus_pkg::data_t     bus_dout,
	output logic                   ppu_rd,
	output logic                   ppu_wr,
	output nes_bus_pkg::data_t     cpu_din,
	output logic                   pause_cpu,
	output logic                   dmc_ack,
	output logic                   dma_active,
	output logic [2:0]             joypad_out,
	output logic [1:0]             joypad_clock
);
	import nes_bus_pkg::*;

	logic       put_cycle;
	logic       ppu_read_slot;
	logic       ppu_write_slot;
	addr_t      dma_addr;
	logic       dma_read;
	data_t      dma_wdata;
	data_t      dma_rdata;
	logic       sprite_trigger;
	logic       joy1_cs;
	logic       joy2_cs;
	logic [4:0] joy_rdata;

	clock_divider clock_divider_i (
		.clk            (clk),
		.reset          (reset),
		.sys_type       (sys_type),
		.cpu_ce         (cpu_ce),
		.ppu_ce         (ppu_ce),
		.put_ce         (put_ce),
		.get_ce         (get_ce),
		.cart_ce        (cart_ce),
		.put_cycle      (put_cycle),
		.ppu_read_slot  (ppu_read_slot),
		.ppu_write_slot (ppu_write_slot)
	);

	dma_controller dma_controller_i (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.put_ce         (put_ce),
		.get_ce         (get_ce),
		.put_cycle      (put_cycle),
		.sprite_trigger (sprite_trigger),
		.cpu_read       (cpu_rnw),
		.cpu_wdata      (cpu_wdata),
		.dma_rdata      (dma_rdata),
		.dmc_request    (dmc_request),
		.dmc_addr       (dmc_addr),
		.dma_addr       (dma_addr),
		.dma_active     (dma_active),
		.dma_read       (dma_read),
		.dma_wdata      (dma_wdata),
		.dmc_ack        (dmc_ack),
		.pause_cpu      (pause_cpu)
	);

	joypad_port joypad_port_i (
		.clk          (clk),
		.reset        (reset),
		.put_ce       (put_ce),
		.joy1_cs      (joy1_cs),
		.joy2_cs      (joy2_cs),
		.cpu_read     (cpu_rnw),
		.cpu_wdata    (cpu_wdata),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock),
		.joy_rdata    (joy_rdata)
	);

	cpu_bus_mux cpu_bus_mux_i (
		.clk            (clk),
		.reset          (reset),
		.cpu_ce         (cpu_ce),
		.cpu_addr       (cpu_addr),
		.cpu_rnw        (cpu_rnw),
		.cpu_wdata      (cpu_wdata),
		.dma_addr       (dma_addr),
		.dma_active     (dma_active),
		.dma_read       (dma_read),
		.dma_wdata      (dma_wdata),
		.ppu_read_slot  (ppu_read_slot),
		.ppu_write_slot (ppu_write_slot),
		.ppu_rdata      (ppu_rdata),
		.prg_allow      (prg_allow),
		.prg_rdata      (prg_rdata),
		.joy_rdata      (joy_rdata),
		.bus_addr       (bus_addr),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_dout       (bus_dout),
		.ppu_rd         (ppu_rd),
		.ppu_wr         (ppu_wr),
		.sprite_trigger (sprite_trigger),
		.joy1_cs        (joy1_cs),
		.joy2_cs        (joy2_cs),
		.cpu_din        (cpu_din),
		.dma_rdata      (dma_rdata)
	);

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset source. 10 ns clock, reset held high
 * for the first 16 rising edges.
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- nes_bus_tb.sv
/*
 * Vector driven testbench for the CPU bus core. Steps come from
 * nes_bus_vectors.txt, four hex fields each. Inputs change 1 ns after
 * the rising edge, outputs are sampled on the falling edge.
 * A RAM model backs prg_rdata with an address dependent fill.
 */

`timescale 1ns/1ps

module nes_bus_tb;
	import nes_bus_pkg::*;

	localparam logic [31:0] SEED      = 32'hca4f_76cf;
	localparam int          MAX_STEPS = 64;

	logic       clk;
	logic       reset;
	sys_type_e  sys_type;
	addr_t      cpu_addr;
	logic       cpu_rnw;
	data_t      cpu_wdata;
	data_t      ppu_rdata;
	logic       prg_allow;
	data_t      prg_rdata;
	logic       dmc_request;
	addr_t      dmc_addr;
	logic [4:0] joypad1_data;
	logic [4:0] joypad2_data;
	logic       cpu_ce;
	logic       ppu_ce;
	logic       put_ce;
	logic       get_ce;
	logic       cart_ce;
	addr_t      bus_addr;
	logic       bus_read;
	logic       bus_write;
	data_t      bus_dout;
	logic       ppu_rd;
	logic       ppu_wr;
	data_t      cpu_din;
	logic       pause_cpu;
	logic       dmc_ack;
	logic       dma_active;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;

	logic [15:0] vec_mem [0:4*MAX_STEPS-1];	// op, a, b, expect per step
	data_t       ram [0:65535];
	int          errors;
	int          step_errors;
	int          steps;
	logic        seen_rd;	// Flags gathered over one CPU cycle
	logic        seen_wr;
	logic [1:0]  seen_clk;
	data_t       din_at_ce;

	tb_clock_gen clock_gen_i (
		.clk   (clk),
		.reset (reset)
	);

	nes_bus_top nes_bus_top_i (
		.clk          (clk),
		.reset        (reset),
		.sys_type     (sys_type),
		.cpu_addr     (cpu_addr),
		.cpu_rnw      (cpu_rnw),
		.cpu_wdata    (cpu_wdata),
		.ppu_rdata    (ppu_rdata),
		.prg_allow    (prg_allow),
		.prg_rdata    (prg_rdata),
		.dmc_request  (dmc_request),
		.dmc_addr     (dmc_addr),
		.joypad1_data (joypad1_data),
		.joypad2_data (joypad2_data),
		.cpu_ce       (cpu_ce),
		.ppu_ce       (ppu_ce),
		.put_ce       (put_ce),
		.get_ce       (get_ce),
		.cart_ce      (cart_ce),
		.bus_addr     (bus_addr),
		.bus_read     (bus_read),
		.bus_write    (bus_write),
		.bus_dout     (bus_dout),
		.ppu_rd       (ppu_rd),
		.ppu_wr       (ppu_wr),
		.cpu_din      (cpu_din),
		.pause_cpu    (pause_cpu),
		.dmc_ack      (dmc_ack),
		.dma_active   (dma_active),
		.joypad_out   (joypad_out),
		.joypad_clock (joypad_clock)
	);

	// RAM model, read side is combinational
	assign prg_rdata = ram[bus_addr];

	// Writes land on the CPU edge, PPU and APU windows excluded
	always @(posedge clk) begin
		if (!reset && cpu_ce && bus_write && !(bus_addr >= 16'h2000 && bus_addr <= 16'h3FFF)
		    && bus_addr[15:5] != 11'b0100_0000_000)
			ram[bus_addr] <= bus_dout;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Fill byte depends on all sixteen address bits
	function automatic data_t fill_byte(input addr_t a);
		logic [31:0] v;
		v = lcg_next(lcg_next(SEED ^ {a, a}));
		return v[31:24];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h, expected %h", name, got, exp);
			errors++;
			step_errors++;
		end
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		errors++;
		step_errors++;
	endtask

	task automatic next_clock;	// Back to the drive point
		@(posedge clk);
		#1;
	endtask

	// Loops until a sampled cpu_ce, leaves just after that CPU edge
	task automatic wait_cpu_ce(output logic ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 40) begin
			@(negedge clk);
			ok = cpu_ce;
			next_clock;
			n++;
		end
		if (!ok)
			report_problem("No cpu_ce seen within 40 clocks");
	endtask

	// One external CPU bus cycle, held until the CPU edge
	task automatic run_cpu_cycle(input addr_t addr, input logic rnw, input data_t wdata);
		int   n;
		logic done;
		cpu_addr  = addr;
		cpu_rnw   = rnw;
		cpu_wdata = wdata;
		seen_rd   = 1'b0;
		seen_wr   = 1'b0;
		seen_clk  = 2'b00;
		done      = 1'b0;
		n         = 0;
		while (!done && n < 40) begin
			@(negedge clk);
			seen_rd  = seen_rd | ppu_rd;
			seen_wr  = seen_wr | ppu_wr;
			seen_clk = seen_clk | joypad_clock;
			if (cpu_ce) begin
				din_at_ce = cpu_din;	// Value the CPU latches
				done      = 1'b1;
			end
			next_clock;
			n++;
		end
		if (!done)
			report_problem("CPU cycle never ended, no cpu_ce within 40 clocks");
	endtask

	task automatic measure_clocks(input logic [1:0] sys, input logic [15:0] exp);
		int   clocks;
		int   ticks;
		int   ces;
		int   puts;
		int   gets;
		int   carts;
		logic ok;
		sys_type = sys_type_e'(sys);
		clocks   = 0;
		ticks    = 0;
		ces      = 0;
		puts     = 0;
		gets     = 0;
		carts    = 0;
		repeat (3) wait_cpu_ce(ok);	// Let the divider realign
		while (ces < 60 && clocks < 2000) begin
			@(negedge clk);
			clocks++;
			ticks += ppu_ce;
			puts  += put_ce;
			gets  += get_ce;
			carts += cart_ce;
			if (cpu_ce)
				ces++;
			next_clock;
		end
		check_value("cpu_ce count", ces, 60);
		check_value("clocks per 60 cpu_ce", clocks, exp);
		check_value("ppu_ce count", ticks, exp / 4);	// One PPU tick per 4 clocks
		check_value("put_ce count", puts, 30);	// Phase alternates every CPU cycle
		check_value("get_ce count", gets, 30);
		check_value("cart_ce count", carts, 60);	// One cart enable per CPU cycle
	endtask

	task automatic run_sprite_dma(input data_t page, input addr_t dmc_a,
	                              input logic [15:0] exp_count);
		addr_t rd_addr[$];
		data_t wr_data[$];
		int    n;
		int    i;
		int    acks;
		logic  seen_active;
		logic  requested;
		logic  finished;
		n           = 0;
		acks        = 0;
		seen_active = 1'b0;
		requested   = 1'b0;
		finished    = 1'b0;
		prg_allow   = 1'b1;
		run_cpu_cycle(16'h4014, 1'b0, page);
		cpu_addr = 16'h8000;	// CPU sits on a read while paused
		cpu_rnw  = 1'b1;
		while (!finished && n < 20000) begin
			@(negedge clk);
			if (cpu_ce && dma_active) begin
				check_value("pause_cpu", pause_cpu, 1);	// CPU held while DMA owns the bus
				if (dmc_ack) begin
					acks++;
					check_value("bus_addr", bus_addr, dmc_a);
					check_value("bus_read", bus_read, 1);
				end else if (bus_read) begin
					rd_addr.push_back(bus_addr);
				end else begin
					check_value("bus_addr", bus_addr, 16'h2004);
					check_value("bus_write", bus_write, 1);
					wr_data.push_back(bus_dout);
				end
			end
			if (dma_active)
				seen_active = 1'b1;
			finished = seen_active && !dma_active && !pause_cpu;
			next_clock;
			n++;
			// DMC steal in the middle of the copy
			if (dmc_a != 16'h0000 && !requested && rd_addr.size() == 40) begin
				dmc_addr    = dmc_a;
				dmc_request = 1'b1;
				requested   = 1'b1;
			end
			if (dmc_ack)
				dmc_request = 1'b0;
		end
		if (!finished)
			report_problem("Sprite DMA did not finish within 20000 clocks");
		check_value("sprite read count", rd_addr.size(), exp_count);
		check_value("sprite write count", wr_data.size(), exp_count);
		for (i = 0; i < rd_addr.size() && i < 256; i++)
			check_value("sprite read addr", rd_addr[i], {page, i[7:0]});
		for (i = 0; i < wr_data.size() && i < 256; i++)
			check_value("oam write data", wr_data[i], ram[{page, i[7:0]}]);
		check_value("dmc_ack count", acks, (dmc_a != 16'h0000) ? 1 : 0);
		dmc_request = 1'b0;
		prg_allow   = 1'b0;
	endtask

	task automatic run_dmc(input addr_t a);
		int   n;
		int   acks;
		logic seen;
		logic finished;
		n           = 0;
		acks        = 0;
		seen        = 1'b0;
		finished    = 1'b0;
		dmc_addr    = a;
		dmc_request = 1'b1;
		while (!finished && n < 400) begin
			@(negedge clk);
			if (dmc_ack && cpu_ce) begin
				acks++;
				check_value("bus_addr", bus_addr, a);
				check_value("bus_read", bus_read, 1);
			end
			if (dmc_ack)
				seen = 1'b1;
			finished = seen && !dmc_ack && !pause_cpu;
			next_clock;
			n++;
			if (dmc_ack)
				dmc_request = 1'b0;	// Request served
		end
		if (!finished)
			report_problem("DMC acknowledge never came within 400 clocks");
		check_value("dmc_ack count", acks, 1);
		dmc_request = 1'b0;
	endtask

	task automatic run_strobe(input data_t value, input logic [15:0] exp);
		int   n;
		logic found;
		n     = 0;
		found = 1'b0;
		run_cpu_cycle(16'h4016, 1'b0, value);
		cpu_addr = 16'h8000;
		cpu_rnw  = 1'b1;
		while (!found && n < 40) begin
			@(negedge clk);
			found = put_ce;
			next_clock;
			n++;
		end
		if (!found)
			report_problem("No put cycle seen after the strobe write");
		@(negedge clk);
		check_value("joypad_out", joypad_out, exp);
		next_clock;
	endtask

	task automatic run_joy_read(input addr_t a, input logic [4:0] pins, input logic [15:0] exp);
		if (a[0]) begin
			joypad2_data = pins;
			joypad1_data = ~pins;	// Other port differs so a wrong select shows
		end else begin
			joypad1_data = pins;
			joypad2_data = ~pins;
		end
		run_cpu_cycle(a, 1'b1, 8'h00);
		check_value("cpu_din", din_at_ce, exp);
		check_value("joypad_clock", seen_clk, a[0] ? 2'b10 : 2'b01);
	endtask

	initial begin
		int   k;
		int   a;
		logic [15:0] op;
		logic [15:0] fa;
		logic [15:0] fb;
		logic [15:0] fe;
		sys_type     = NTSC;
		cpu_addr     = 16'h8000;
		cpu_rnw      = 1'b1;
		cpu_wdata    = 8'h00;
		ppu_rdata    = 8'h00;
		prg_allow    = 1'b0;
		dmc_request  = 1'b0;
		dmc_addr     = 16'h0000;
		joypad1_data = 5'h00;
		joypad2_data = 5'h00;
		errors       = 0;
		steps        = 0;
		for (a = 0; a < 65536; a++)
			ram[a] = fill_byte(a[15:0]);
		for (k = 0; k < 4 * MAX_STEPS; k++)
			vec_mem[k] = 16'h0000;
		$readmemh("nes_bus_vectors.txt", vec_mem);

		k = 0;
		while (reset && k < 100) begin
			@(posedge clk);
			#1;
			k++;
		end
		if (reset)
			report_problem("Reset never released");

		for (k = 0; k < MAX_STEPS && vec_mem[4*k] != 16'h0000 && !reset; k++) begin
			op = vec_mem[4*k];
			fa = vec_mem[4*k+1];
			fb = vec_mem[4*k+2];
			fe = vec_mem[4*k+3];
			step_errors = 0;
			case (op)
				16'h0001: measure_clocks(fb[1:0], fe);
				16'h0002: begin
					run_cpu_cycle(fa, fb[0], 8'h00);
					check_value("ppu_wr/ppu_rd seen", {seen_wr, seen_rd}, fe);
				end
				16'h0003: run_sprite_dma(fa[7:0], fb, fe);
				16'h0004: run_dmc(fa);
				16'h0005: run_strobe(fb[7:0], fe);
				16'h0006: run_cpu_cycle(fa, 1'b0, fb[7:0]);
				16'h0007: run_joy_read(fa, fb[4:0], fe);
				16'h0008: begin
					prg_allow = fb[0];
					run_cpu_cycle(fa, 1'b1, 8'h00);
					check_value("cpu_din", din_at_ce, fe);
					prg_allow = 1'b0;
				end
				default: report_problem("Unknown operation code in the vector file");
			endcase
			steps++;
			$display("Step %0d op %0h addr %h: %s", k, op, fa,
			         (step_errors == 0) ? "ok" : "errors");
		end

		$display("%0d steps run, %0d check errors", steps, errors);
		if (errors == 0 && steps > 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
nes_bus_pkg.sv
clock_divider.sv
dma_controller.sv
joypad_port.sv
cpu_bus_mux.sv
nes_bus_top.sv
tb_clock_gen.sv
nes_bus_tb.sv

//--- nes_bus_vectors.txt
// Columns: op addr b expect, all hex, one step per line
// op 1 clocks, 2 ppu strobe, 3 sprite dma, 4 dmc, 5 strobe, 6 write, 7 pad read, 8 read
// Clock ratios, b is the system type, expect is clocks per 60 cpu_ce
0001 0000 0000 02D0
0001 0000 0001 0300
0001 0000 0002 02D0
0001 0000 0000 02D0
// PPU window strobes, b is rnw, expect is {wr, rd}
0002 2002 0001 0001
0002 2000 0000 0002
0002 3FFF 0001 0001
0002 2007 0000 0002
0002 8000 0001 0000
0002 4000 0000 0000
0002 1FFF 0001 0000
0002 4016 0001 0000
// Sprite DMA, addr is the page, b is a DMC address to steal with
0003 0003 0000 0100
0003 0007 C123 0100
0003 00A5 0000 0100
// DMC fetch on its own
0004 C456 0000 0000
0004 FFC0 0000 0000
// Controller strobe, b is written, expect is joypad_out
0005 4016 0005 0005
0005 4016 0002 0002
0005 4016 0007 0007
0005 4016 0000 0000
// Controller reads, b is the pad pins, expect is cpu_din
0006 5000 00E0 0000
0007 4016 000A 00EA
0007 4017 0015 00F5
0006 5000 0000 0000
0007 4017 001F 001F
0006 5000 00A0 0000
0007 4016 0003 00A3
// Open bus, b is prg_allow
0006 5000 003C 0000
0008 5000 0000 003C
0006 6000 005A 0000
0008 4100 0000 005A
0006 7000 0081 0000
0008 5555 0000 0081
0000 0000 0000 0000
